// File: common/corePkg.sv
package corePkg;

    // ========================================
    // widths
    // ========================================

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // ========================================
    // opcodes
    // ========================================

    typedef enum logic [2:0] {
        opAdd,
        opSub,
        opAnd,
        opOr,
        opXor,
        opSlt,
        opMul,
        opIllegal
    } aluOp_t;

    // ========================================
    // stage records
    // ========================================

    // decoded instruction as it leaves the queue head
    typedef struct packed {
        logic                  valid;
        aluOp_t                op;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic                  useImm;
        logic [XLEN-1:0]       imm;     // sign extended I immediate
        logic [28:0]           pad;     // rounds the uop up to 81 bits
    } decUop_t;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic                  illegal;
        logic [XLEN-1:0]       value;
        logic                  spare;   // keeps the record at 40 bits
    } resUop_t;

    // retire record seen outside the core
    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic                  illegal;
        logic [XLEN-1:0]       value;
        logic                  spare;
    } commit_t;

endpackage

// File: logic/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder import corePkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            instrValid,
    input  logic [XLEN-1:0] instr,
    input  logic            execReady,
    output logic            creditReturn,
    output decUop_t         decUop
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    logic [XLEN-1:0]  queue [QUEUE_DEPTH];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic             pop;
    logic [XLEN-1:0]  headInstr;
    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic             isImm;
    aluOp_t           op;

    // wraps at QUEUE_DEPTH so the depth need not be a power of two
    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // ========================================
    // queue
    // ========================================

    always_ff @(posedge clk) begin
        if (instrValid) begin
            queue[tail] <= instr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (instrValid) begin
                tail <= nextPtr(tail);
            end
            if (pop) begin
                head <= nextPtr(head);
            end
            count <= count + CNT_W'(instrValid) - CNT_W'(pop);
        end
    end

    assign pop          = decUop.valid && execReady;
    assign creditReturn = pop;     // one credit back per instruction that leaves

    // ========================================
    // decode of the head entry
    // ========================================

    assign headInstr = queue[head];
    assign opcode    = headInstr[6:0];
    assign funct3    = headInstr[14:12];
    assign funct7    = headInstr[31:25];
    assign isImm     = (opcode == OPC_OP_IMM);

    always_comb begin
        op = opIllegal;
        if (opcode == OPC_OP) begin
            case ({funct7, funct3})
                {7'b0000000, 3'b000}: op = opAdd;
                {7'b0100000, 3'b000}: op = opSub;
                {7'b0000000, 3'b111}: op = opAnd;
                {7'b0000000, 3'b110}: op = opOr;
                {7'b0000000, 3'b100}: op = opXor;
                {7'b0000000, 3'b010}: op = opSlt;
                {7'b0000001, 3'b000}: op = opMul;
                default:              op = opIllegal;
            endcase
        end else if (isImm && funct3 == 3'b000) begin
            op = opAdd;                // ADDI
        end
    end

    // unknown encodings keep rd at zero so they can never name a destination
    always_comb begin
        decUop       = '0;
        decUop.valid = (count != '0);
        decUop.op    = op;
        if (op != opIllegal) begin
            decUop.rd     = headInstr[11:7];
            decUop.rs1    = headInstr[19:15];
            decUop.rs2    = isImm ? '0 : headInstr[24:20];
            decUop.useImm = isImm;
            decUop.imm    = isImm ? {{20{headInstr[31]}}, headInstr[31:20]} : '0;
        end
    end

    // a push into a full queue means the sender spent a credit it did not hold
    assert property (@(posedge clk) disable iff (rst)
        instrValid |-> count != CNT_W'(QUEUE_DEPTH))
        else $error("credit violation, instrValid with a full queue");

endmodule

// File: logic/regFile.sv
`timescale 1ns/1ps

module regFile import corePkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [REG_ADDR_W-1:0] rdAddrA,
    input  logic [REG_ADDR_W-1:0] rdAddrB,
    input  resUop_t               wbUop,
    output logic [XLEN-1:0]       rdDataA,
    output logic [XLEN-1:0]       rdDataB
);

    logic [XLEN-1:0] regs [NUM_REGS];
    logic            wrEn;

    // illegal results retire but never touch the architectural state
    assign wrEn = wbUop.valid && !wbUop.illegal && (wbUop.rd != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wbUop.rd] <= wbUop.value;
        end
    end

    // ========================================
    // read ports
    // ========================================

    assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];    // x0 reads as zero
    assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

// File: execute/multiplier.sv
`timescale 1ns/1ps

module multiplier import corePkg::*; #(
    parameter int MUL_LATENCY = 3
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            mulStart,
    input  logic [XLEN-1:0] opA,
    input  logic [XLEN-1:0] opB,
    output logic            mulBusy,
    output logic [XLEN-1:0] mulResult
);

    localparam int CNT_W = (MUL_LATENCY > 1) ? $clog2(MUL_LATENCY) : 1;

    logic [CNT_W-1:0] count;
    logic [XLEN-1:0]  opAQ;
    logic [XLEN-1:0]  opBQ;

    // ========================================
    // operand hold
    // ========================================

    always_ff @(posedge clk) begin
        if (mulStart) begin
            opAQ <= opA;
            opBQ <= opB;
        end
    end

    // ========================================
    // countdown
    // ========================================

    // the start cycle is the first of the MUL_LATENCY cycles
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (mulStart) begin
            count <= CNT_W'(MUL_LATENCY - 1);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign mulBusy = (count != '0);

    // only the low half of the product is architectural
    assign mulResult = opAQ * opBQ;

endmodule

// File: execute/execUnit.sv
`timescale 1ns/1ps

module execUnit import corePkg::*; #(
    parameter int MUL_LATENCY = 3
) (
    input  logic                  clk,
    input  logic                  rst,
    input  decUop_t               decUop,
    input  logic [XLEN-1:0]       rdDataA,
    input  logic [XLEN-1:0]       rdDataB,
    input  resUop_t               wbUop,
    output logic                  execReady,
    output logic [REG_ADDR_W-1:0] rdAddrA,
    output logic [REG_ADDR_W-1:0] rdAddrB,
    output resUop_t               exUop
);

    logic                  transfer;
    logic [XLEN-1:0]       srcA;
    logic [XLEN-1:0]       srcB;
    logic [XLEN-1:0]       opA;
    logic [XLEN-1:0]       opB;
    logic [XLEN-1:0]       aluResult;
    logic                  mulStart;
    logic                  mulBusy;
    logic [XLEN-1:0]       mulResult;
    logic                  mulPending;
    logic                  mulDone;
    logic [REG_ADDR_W-1:0] mulRd;

    // the newest producer wins, so exUop is checked before wbUop
    function automatic logic [XLEN-1:0] forward(
        input logic [REG_ADDR_W-1:0] addr,
        input logic [XLEN-1:0]       rfData,
        input resUop_t               exSrc,
        input resUop_t               wbSrc
    );
        if (exSrc.valid && !exSrc.illegal && exSrc.rd != '0 && exSrc.rd == addr) begin
            return exSrc.value;
        end
        if (wbSrc.valid && !wbSrc.illegal && wbSrc.rd != '0 && wbSrc.rd == addr) begin
            return wbSrc.value;
        end
        return rfData;
    endfunction

    // ========================================
    // operands
    // ========================================

    assign rdAddrA = decUop.rs1;
    assign rdAddrB = decUop.rs2;

    assign srcA = forward(rdAddrA, rdDataA, exUop, wbUop);
    assign srcB = forward(rdAddrB, rdDataB, exUop, wbUop);
    assign opA  = srcA;
    assign opB  = decUop.useImm ? decUop.imm : srcB;

    always_comb begin
        case (decUop.op)
            opAdd:   aluResult = opA + opB;
            opSub:   aluResult = opA - opB;
            opAnd:   aluResult = opA & opB;
            opOr:    aluResult = opA | opB;
            opXor:   aluResult = opA ^ opB;
            opSlt:   aluResult = XLEN'($signed(opA) < $signed(opB));
            default: aluResult = '0;
        endcase
    end

    // ========================================
    // issue gate and multiplier hand-off
    // ========================================

    // a pending MUL holds the slot until its product is registered
    assign execReady = !mulPending;
    assign transfer  = decUop.valid && execReady;
    assign mulStart  = transfer && (decUop.op == opMul);
    assign mulDone   = mulPending && !mulBusy;

    multiplier #(
        .MUL_LATENCY(MUL_LATENCY)
    ) mul_i (
        .clk      (clk),
        .rst      (rst),
        .mulStart (mulStart),
        .opA      (opA),
        .opB      (opB),
        .mulBusy  (mulBusy),
        .mulResult(mulResult)
    );

    always_ff @(posedge clk) begin
        if (mulStart) begin
            mulRd <= decUop.rd;
        end
        exUop.rd      <= mulDone ? mulRd : decUop.rd;
        exUop.value   <= mulDone ? mulResult : aluResult;
        exUop.illegal <= !mulDone && (decUop.op == opIllegal);
        exUop.spare   <= 1'b0;
        if (rst) begin
            mulPending  <= 1'b0;
            exUop.valid <= 1'b0;
        end else begin
            mulPending  <= mulStart || (mulPending && !mulDone);
            exUop.valid <= (transfer && decUop.op != opMul) || mulDone;
        end
    end

    // the multiplier countdown has to end inside the pending window of the previous MUL
    assert property (@(posedge clk) disable iff (rst) mulStart |-> !mulBusy)
        else $error("mulStart while the multiplier is busy");

endmodule

// File: logic/resultStage.sv
`timescale 1ns/1ps

module resultStage import corePkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  resUop_t exUop,
    output resUop_t wbUop,
    output commit_t commit
);

    // ========================================
    // result register
    // ========================================

    // wbUop feeds the register file write and the forwarding path in execute
    always_ff @(posedge clk) begin
        wbUop <= exUop;
        if (rst) begin
            wbUop.valid <= 1'b0;
        end
    end

    // ========================================
    // retire port
    // ========================================

    assign commit.valid   = wbUop.valid;    // one pulse per retired instruction
    assign commit.rd      = wbUop.rd;
    assign commit.illegal = wbUop.illegal;
    assign commit.value   = wbUop.value;
    assign commit.spare   = wbUop.spare;

    // decode drops rd for unknown encodings and execute carries that through
    assert property (@(posedge clk) disable iff (rst)
        wbUop.valid && wbUop.illegal |-> wbUop.rd == '0)
        else $error("illegal result names destination x%0d", wbUop.rd);

endmodule

// File: logic/coreTop.sv
`timescale 1ns/1ps

module coreTop import corePkg::*; #(
    parameter int QUEUE_DEPTH = 4,
    parameter int MUL_LATENCY = 3
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            instrValid,
    input  logic [XLEN-1:0] instr,
    output logic            creditReturn,
    output commit_t         commit
);

    decUop_t               decUop;
    logic                  execReady;
    logic [REG_ADDR_W-1:0] rdAddrA;
    logic [REG_ADDR_W-1:0] rdAddrB;
    logic [XLEN-1:0]       rdDataA;
    logic [XLEN-1:0]       rdDataB;
    resUop_t               exUop;
    resUop_t               wbUop;

    // ========================================
    // stages
    // ========================================

    instrDecoder #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) dec_i (
        .clk         (clk),
        .rst         (rst),
        .instrValid  (instrValid),
        .instr       (instr),
        .execReady   (execReady),
        .creditReturn(creditReturn),
        .decUop      (decUop)
    );

    regFile rf_i (
        .clk    (clk),
        .rst    (rst),
        .rdAddrA(rdAddrA),
        .rdAddrB(rdAddrB),
        .wbUop  (wbUop),
        .rdDataA(rdDataA),
        .rdDataB(rdDataB)
    );

    execUnit #(
        .MUL_LATENCY(MUL_LATENCY)
    ) ex_i (
        .clk      (clk),
        .rst      (rst),
        .decUop   (decUop),
        .rdDataA  (rdDataA),
        .rdDataB  (rdDataB),
        .wbUop    (wbUop),
        .execReady(execReady),
        .rdAddrA  (rdAddrA),
        .rdAddrB  (rdAddrB),
        .exUop    (exUop)
    );

    resultStage res_i (
        .clk   (clk),
        .rst   (rst),
        .exUop (exUop),
        .wbUop (wbUop),
        .commit(commit)
    );

endmodule

// File: test/refModel.svh
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

// architectural state in program order, x0 is never written
logic [XLEN-1:0] modelRegs [NUM_REGS];

task automatic modelClear();
    for (int i = 0; i < NUM_REGS; i++) begin
        modelRegs[i] = '0;
    end
endtask

// RV32I/M subset as the ISA defines it, everything else is unsupported
function automatic aluOp_t modelDecode(input logic [31:0] word);
    logic [9:0] fn;
    fn = {word[31:25], word[14:12]};
    if (word[6:0] == 7'b0010011 && word[14:12] == 3'b000) begin
        return opAdd;                       // ADDI
    end
    if (word[6:0] != 7'b0110011) begin
        return opIllegal;
    end
    case (fn)
        10'b0000000_000: return opAdd;
        10'b0100000_000: return opSub;
        10'b0000000_111: return opAnd;
        10'b0000000_110: return opOr;
        10'b0000000_100: return opXor;
        10'b0000000_010: return opSlt;
        10'b0000001_000: return opMul;
        default:         return opIllegal;
    endcase
endfunction

// applies one instruction and returns the record it should retire with
function automatic commit_t modelStep(input logic [31:0] word);
    commit_t         rec;
    aluOp_t          op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    op = modelDecode(word);
    rec = '0;
    rec.valid = 1'b1;
    if (op == opIllegal) begin
        rec.illegal = 1'b1;                 // retires without a destination
        return rec;
    end
    a = modelRegs[word[19:15]];
    b = (word[6:0] == 7'b0010011) ? {{20{word[31]}}, word[31:20]} : modelRegs[word[24:20]];
    case (op)
        opAdd:   rec.value = a + b;
        opSub:   rec.value = a - b;
        opAnd:   rec.value = a & b;
        opOr:    rec.value = a | b;
        opXor:   rec.value = a ^ b;
        opSlt:   rec.value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        opMul:   rec.value = a * b;         // low half only
        default: rec.value = '0;
    endcase
    rec.rd = word[11:7];
    if (rec.rd != '0) begin
        modelRegs[rec.rd] = rec.value;
    end
    return rec;
endfunction

`endif

// File: test/coreTb.sv
`timescale 1ns/1ps

module coreTb import corePkg::*; #(
    parameter int QUEUE_DEPTH = 4,
    parameter int MUL_LATENCY = 3
);

    localparam int N_ALU = 40;
    localparam int N_ZERO = 8;          // pairs of x0 write and x0 read
    localparam int N_FWD = 24;
    localparam int N_MUL = 32;
    localparam int N_ILL = 8;           // pairs of illegal and read back
    localparam int TOTAL_INSTR = (NUM_REGS - 1) + N_ALU + 2 * N_ZERO + N_FWD + N_MUL + 2 * N_ILL;
    localparam int WATCHDOG_CYCLES = TOTAL_INSTR * (MUL_LATENCY + 4) + 100;

    logic            clk = 1'b0;
    logic            rst;
    logic            instrValid;
    logic [XLEN-1:0] instr;
    logic            creditReturn;
    commit_t         commit;

    integer  seed = 38979;
    int      credits;
    int      sentCount;
    int      creditPulses;
    int      commitCount;
    int      errorCount;
    int      testStartErrors;
    int      passCount;
    int      failCount;
    string   testName;
    commit_t expQ [$];

    `include "refModel.svh"

    coreTop #(
        .QUEUE_DEPTH(QUEUE_DEPTH),
        .MUL_LATENCY(MUL_LATENCY)
    ) dut_i (
        .clk         (clk),
        .rst         (rst),
        .instrValid  (instrValid),
        .instr       (instr),
        .creditReturn(creditReturn),
        .commit      (commit)
    );

    always #10 clk = ~clk;

    // ========================================
    // encoding and random picks
    // ========================================

    function automatic logic [XLEN-1:0] encode(input int kind, input logic [4:0] rd,
            input logic [4:0] rs1, input logic [4:0] rs2, input logic [11:0] imm);
        case (kind)
            0:       return {7'h00, rs2, rs1, 3'b000, rd, 7'b0110011};
            1:       return {7'h20, rs2, rs1, 3'b000, rd, 7'b0110011};
            2:       return {7'h00, rs2, rs1, 3'b111, rd, 7'b0110011};
            3:       return {7'h00, rs2, rs1, 3'b110, rd, 7'b0110011};
            4:       return {7'h00, rs2, rs1, 3'b100, rd, 7'b0110011};
            5:       return {7'h00, rs2, rs1, 3'b010, rd, 7'b0110011};
            6:       return {imm, rs1, 3'b000, rd, 7'b0010011};
            default: return {7'h01, rs2, rs1, 3'b000, rd, 7'b0110011};
        endcase
    endfunction

    function automatic logic [4:0] randReg();
        logic [31:0] r;
        r = $random(seed);
        return r[4:0];
    endfunction

    function automatic logic [4:0] randDest();
        logic [4:0] r;
        r = randReg();
        return (r == 5'd0) ? 5'd1 : r;
    endfunction

    function automatic logic [XLEN-1:0] randOp(input bit withMul, input logic [4:0] rd,
            input logic [4:0] rs1, input logic [4:0] rs2);
        logic [31:0] r;
        int          kind;
        r = $random(seed);
        kind = int'(r[2:0]) % 7;
        if (withMul && r[3]) begin
            kind = 7;                   // about half of the mix is MUL
        end
        return encode(kind, rd, rs1, rs2, r[31:20]);
    endfunction

    // M ops other than MUL, SRA-style funct7, OP-IMM other than ADDI, and loads
    function automatic logic [XLEN-1:0] illegalWord(input logic [4:0] rd);
        logic [31:0] w;
        logic [1:0]  sel;
        w = $random(seed);
        sel = w[1:0];
        w[11:7] = rd;
        case (sel)
            2'd0:    w = {7'b0000001, w[24:13], 1'b1, w[11:7], 7'b0110011};
            2'd1:    w = {7'b0100000, w[24:13], 1'b1, w[11:7], 7'b0110011};
            2'd2:    w = {w[31:13], 1'b1, w[11:7], 7'b0010011};
            default: w[6:0] = 7'b0000011;
        endcase
        return w;
    endfunction

    function automatic string fmtRec(input commit_t rec);
        return $sformatf("valid=%0b rd=x%0d illegal=%0b value=%h spare=%0b",
                         rec.valid, rec.rd, rec.illegal, rec.value, rec.spare);
    endfunction

    // ========================================
    // sender, drain and report
    // ========================================

    task automatic sendInstr(input logic [XLEN-1:0] word);
        @(posedge clk);
        #1;
        if (credits == 0) begin
            assert (expQ.size() != 0) else begin
                $display("sender holds no credits while the core is idle");
                errorCount++;
            end
        end
        while (credits == 0) begin
            instrValid = 1'b0;
            @(posedge clk);
            #1;
        end
        instrValid = 1'b1;
        instr      = word;
        credits--;
        sentCount++;
        expQ.push_back(modelStep(word));
    endtask

    task automatic startTest(input string name);
        testName        = name;
        testStartErrors = errorCount;
    endtask

    task automatic reportTest();
        if (errorCount == testStartErrors) begin
            passCount++;
            $display("test %s: PASS", testName);
        end else begin
            failCount++;
            $display("test %s: FAIL (%0d errors)", testName, errorCount - testStartErrors);
        end
    endtask

    // every credit is back once all sent instructions have retired
    task automatic finishTest();
        @(posedge clk);
        #1;
        instrValid = 1'b0;
        while (expQ.size() != 0) begin
            @(negedge clk);
        end
        assert (credits == QUEUE_DEPTH) else begin
            $display("FAILED %s expected credits %0d actual %0d", testName, QUEUE_DEPTH, credits);
            errorCount++;
        end
        reportTest();
    endtask

    // outputs are read half a cycle after the edge that moved them
    always @(negedge clk) begin
        commit_t exp;
        commit_t got;
        if (!rst) begin
            if (creditReturn) begin
                credits++;
                creditPulses++;
            end
            if (commit.valid) begin
                commitCount++;
                assert (expQ.size() != 0) else begin
                    $display("commit seen with no instruction outstanding in %s", testName);
                    errorCount++;
                end
                if (expQ.size() != 0) begin
                    exp = expQ.pop_front();
                    got = commit;
                    if (exp.illegal) begin
                        got.value = exp.value;  // an illegal result has no defined value
                    end
                    assert (got === exp) else begin
                        $display("FAILED %s expected %s actual %s",
                                 testName, fmtRec(exp), fmtRec(commit));
                        errorCount++;
                    end
                end
            end
        end
    end

    // ========================================
    // tests
    // ========================================

    initial begin
        logic [4:0]      rd;
        logic [4:0]      prevRd;
        logic [4:0]      prev2Rd;
        logic [XLEN-1:0] word;
        rst          = 1'b1;
        instrValid   = 1'b0;
        instr        = '0;
        credits      = QUEUE_DEPTH;
        sentCount    = 0;
        creditPulses = 0;
        commitCount  = 0;
        errorCount   = 0;
        passCount    = 0;
        failCount    = 0;
        modelClear();
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        startTest("aluOps");
        for (int r = 1; r < NUM_REGS; r++) begin
            word = $random(seed);
            sendInstr(encode(6, 5'(r), 5'd0, 5'd0, word[11:0]));
        end
        for (int i = 0; i < N_ALU; i++) begin
            sendInstr(randOp(1'b0, randReg(), randReg(), randReg()));
        end
        finishTest();

        startTest("zeroReg");
        for (int i = 0; i < N_ZERO; i++) begin
            sendInstr(randOp(1'b0, 5'd0, randReg(), randReg()));
            sendInstr(encode(0, randDest(), 5'd0, randReg(), 12'd0));   // x0 plus a register
        end
        finishTest();

        startTest("forwarding");
        for (int c = 0; c < N_FWD / 6; c++) begin
            prev2Rd = randReg();
            prevRd  = randDest();
            for (int k = 0; k < 6; k++) begin
                rd = randDest();
                sendInstr(randOp(1'b0, rd, prevRd, prev2Rd));
                prev2Rd = prevRd;
                prevRd  = rd;
            end
        end
        finishTest();

        startTest("multiply");
        for (int i = 0; i < N_MUL; i++) begin
            sendInstr(randOp(1'b1, randDest(), randReg(), randReg()));
        end
        finishTest();

        startTest("illegal");
        for (int i = 0; i < N_ILL; i++) begin
            rd = randDest();
            sendInstr(illegalWord(rd));
            sendInstr(encode(0, randDest(), rd, 5'd0, 12'd0));
        end
        finishTest();

        startTest("creditFlow");
        assert (creditPulses == sentCount) else begin
            $display("FAILED %s expected %0d credit returns actual %0d",
                     testName, sentCount, creditPulses);
            errorCount++;
        end
        assert (commitCount == sentCount) else begin
            $display("FAILED %s expected %0d commits actual %0d", testName, sentCount, commitCount);
            errorCount++;
        end
        reportTest();

        $display("tests passed: %0d, failed: %0d", passCount, failCount);
        if (failCount == 0 && errorCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        repeat (5 + WATCHDOG_CYCLES) @(posedge clk);
        $display("run timed out after %0d cycles", WATCHDOG_CYCLES);
        $display("Some tests failed");
        $finish;
    end

endmodule

// File: all.f
+incdir+test
common/corePkg.sv
logic/instrDecoder.sv
logic/regFile.sv
execute/multiplier.sv
execute/execUnit.sv
logic/resultStage.sv
logic/coreTop.sv
test/coreTb.sv

// File: Makefile
# Verilator build and run of the core testbench

VERILATOR   ?= verilator
TOP         ?= coreTb
FILELIST    ?= all.f
BUILD_DIR   ?= obj_dir
QUEUE_DEPTH ?= 4
MUL_LATENCY ?= 3
EXTRA_FLAGS ?= -Wno-fatal
PASS_TEXT   ?= All tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench, check the result"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR QUEUE_DEPTH MUL_LATENCY EXTRA_FLAGS"

test:
	$(VERILATOR) --binary --assert $(EXTRA_FLAGS) --top-module $(TOP) \
		-GQUEUE_DEPTH=$(QUEUE_DEPTH) -GMUL_LATENCY=$(MUL_LATENCY) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
